/* hw/vmem_pkg.sv */
/*
 * Vector memory unit shared definitions
 * Lane geometry, op word layout, pattern and size codes, bus word views
 */
package vmem_pkg;

  // Lane geometry
  localparam int NUM_LANES = 4;
  localparam int LANE_W = 2;
  localparam int WORD_W = 32;
  localparam int SEL_W = 4;

  // Op word is pattern, size, signed, we from the top down
  localparam int OP_W = 6;
  localparam int OP_PAT_HI = 5;
  localparam int OP_PAT_LO = 4;
  localparam int OP_SIZE_HI = 3;
  localparam int OP_SIZE_LO = 2;
  localparam int OP_SIGNED = 1;
  localparam int OP_WE = 0;

  // Access pattern codes
  localparam logic [1:0] PAT_UNIT = 2'd0;
  localparam logic [1:0] PAT_STRIDE = 2'd1;
  localparam logic [1:0] PAT_INDEX = 2'd2;

  // Element size codes
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // One bus word, seen as bytes or as halfwords
  // Index 0 is the least significant byte lane
  typedef union packed {
    logic [SEL_W-1:0][7:0] b;
    logic [1:0][15:0] h;
  } mem_word_t;

endpackage

/* hw/vmem_store_align.sv */
/*
 * Store data aligner
 * Replicates the element over the bus word and sets the byte selects
 */
`timescale 1ns/1ps

module vmem_store_align (
  input  logic [vmem_pkg::WORD_W-1:0] wdata,
  input  logic [1:0] addr_lo,
  input  logic [1:0] size,
  output logic [vmem_pkg::SEL_W-1:0] sel,
  output logic [vmem_pkg::WORD_W-1:0] dat
);
  import vmem_pkg::*;

  mem_word_t word;

  always_comb
  begin
    word = '0;
    sel = '0;
    case (size)
      SIZE_BYTE:
      begin
        // Byte lives on every lane, select picks one
        word.b = {SEL_W{wdata[7:0]}};
        sel = SEL_W'(1) << addr_lo;
      end
      SIZE_HALF:
      begin
        word.h = {2{wdata[15:0]}};
        sel = SEL_W'(3) << {addr_lo[1], 1'b0};
      end
      SIZE_WORD:
      begin
        word = wdata;
        sel = '1;
      end
      // Reserved size code writes nothing
      default: sel = '0;
    endcase
  end

  assign dat = word;

endmodule

/* hw/vmem_addr_gen.sv */
/*
 * Vector memory address generation stage
 * Captures one instruction and registers a per-lane address for it
 */
`timescale 1ns/1ps

module vmem_addr_gen (
  input  logic clk,
  input  logic resetn,
  input  logic req_valid,
  input  logic [vmem_pkg::OP_W-1:0] op,
  input  logic [vmem_pkg::WORD_W-1:0] base,
  input  logic [vmem_pkg::WORD_W-1:0] stride,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] vindex,
  input  logic [vmem_pkg::NUM_LANES-1:0] vmask,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] vwritedata,
  input  logic gen_take,
  output logic req_ready,
  output logic gen_valid,
  output logic [vmem_pkg::OP_W-1:0] gen_op,
  output logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] gen_addr,
  output logic [vmem_pkg::NUM_LANES-1:0] gen_mask,
  output logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] gen_wdata
);
  import vmem_pkg::*;

  logic [1:0] pat;
  logic [1:0] size;
  logic [WORD_W-1:0] step;
  logic [NUM_LANES-1:0][WORD_W-1:0] addr_next;
  logic accept;

  assign pat = op[OP_PAT_HI:OP_PAT_LO];
  assign size = op[OP_SIZE_HI:OP_SIZE_LO];

  // Element step in bytes, unit stride steps one element
  assign step = ((pat == PAT_STRIDE) ? stride : WORD_W'(1)) << size;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      case (pat)
        PAT_UNIT, PAT_STRIDE: addr_next[i] = base + step * WORD_W'(i);
        // Index is a byte offset per lane
        PAT_INDEX: addr_next[i] = base + vindex[i];
        default: addr_next[i] = base;
      endcase
    end
  end

  // Slot frees up in the same cycle stage 2 copies it
  assign req_ready = !gen_valid || gen_take;
  assign accept = req_valid && req_ready;

  always_ff @(posedge clk)
  begin
    if (!resetn)
      gen_valid <= 1'b0;
    else if (accept)
      gen_valid <= 1'b1;
    else if (gen_take)
      gen_valid <= 1'b0;
  end

  // Payload held until taken
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      gen_op <= op;
      gen_addr <= addr_next;
      gen_mask <= vmask;
      gen_wdata <= vwritedata;
    end
  end

endmodule

/* hw/vmem_lane_issue.sv */
/*
 * Vector memory lane issue stage
 * Walks the enabled lanes and runs one Wishbone classic access per lane
 */
`timescale 1ns/1ps

module vmem_lane_issue (
  input  logic clk,
  input  logic resetn,
  input  logic gen_valid,
  input  logic [vmem_pkg::OP_W-1:0] gen_op,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] gen_addr,
  input  logic [vmem_pkg::NUM_LANES-1:0] gen_mask,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] gen_wdata,
  input  logic [vmem_pkg::WORD_W-1:0] wb_dat_i,
  input  logic wb_ack,
  output logic gen_take,
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic [vmem_pkg::WORD_W-1:0] wb_adr,
  output logic [vmem_pkg::SEL_W-1:0] wb_sel,
  output logic [vmem_pkg::WORD_W-1:0] wb_dat_o,
  output logic lane_valid,
  output logic [vmem_pkg::LANE_W-1:0] lane_idx,
  output logic [1:0] lane_addr_lo,
  output logic [vmem_pkg::WORD_W-1:0] lane_rdata,
  output logic [1:0] lane_size,
  output logic lane_signed,
  output logic instr_end,
  output logic end_we,
  output logic [vmem_pkg::NUM_LANES-1:0] end_mask
);
  import vmem_pkg::*;

  logic busy_q;
  logic stb_q;
  logic [OP_W-1:0] op_q;
  logic [NUM_LANES-1:0][WORD_W-1:0] addr_q;
  logic [NUM_LANES-1:0][WORD_W-1:0] wdata_q;
  logic [NUM_LANES-1:0] mask_q;
  logic [NUM_LANES-1:0] pend_q;
  logic [NUM_LANES-1:0] pend_clr;
  logic [LANE_W-1:0] lane_q;
  logic [WORD_W-1:0] cur_addr;
  logic bus_ack;

  // Lowest enabled lane goes first
  function automatic logic [LANE_W-1:0] first_lane(input logic [NUM_LANES-1:0] m);
    logic [LANE_W-1:0] r;
    r = '0;
    for (int k = NUM_LANES - 1; k >= 0; k--)
    begin
      if (m[k])
        r = LANE_W'(k);
    end
    return r;
  endfunction

  assign gen_take = gen_valid && !busy_q;
  assign bus_ack = stb_q && wb_ack;
  // Pending lanes once the current one is acked
  assign pend_clr = pend_q & ~(NUM_LANES'(1) << lane_q);
  assign cur_addr = addr_q[lane_q];

  // busy without stb is the one-cycle lane pick after a take
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      busy_q <= 1'b0;
      stb_q <= 1'b0;
      pend_q <= '0;
      lane_q <= '0;
    end
    else if (gen_take)
    begin
      busy_q <= 1'b1;
      pend_q <= gen_mask;
    end
    else if (busy_q && !stb_q)
    begin
      if (pend_q == '0)
        busy_q <= 1'b0;
      else
      begin
        stb_q <= 1'b1;
        lane_q <= first_lane(pend_q);
      end
    end
    else if (bus_ack)
    begin
      pend_q <= pend_clr;
      lane_q <= first_lane(pend_clr);
      // stb stays up straight into the next lane's access
      if (pend_clr == '0)
      begin
        busy_q <= 1'b0;
        stb_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (gen_take)
    begin
      op_q <= gen_op;
      addr_q <= gen_addr;
      wdata_q <= gen_wdata;
      mask_q <= gen_mask;
    end
  end

  vmem_store_align u_store_align (
    .wdata   (wdata_q[lane_q]),
    .addr_lo (cur_addr[1:0]),
    .size    (op_q[OP_SIZE_HI:OP_SIZE_LO]),
    .sel     (wb_sel),
    .dat     (wb_dat_o)
  );

  assign wb_cyc = stb_q;
  assign wb_stb = stb_q;
  assign wb_we = op_q[OP_WE];
  assign wb_adr = {cur_addr[WORD_W-1:2], 2'b00};

  // Load beats to stage 3, one per ack
  assign lane_valid = bus_ack && !op_q[OP_WE];
  assign lane_idx = lane_q;
  assign lane_addr_lo = cur_addr[1:0];
  assign lane_rdata = wb_dat_i;
  assign lane_size = op_q[OP_SIZE_HI:OP_SIZE_LO];
  assign lane_signed = op_q[OP_SIGNED];

  // Last ack, or empty mask right after the take
  assign instr_end = busy_q && ((!stb_q && pend_q == '0) || (bus_ack && pend_clr == '0));
  assign end_we = op_q[OP_WE];
  assign end_mask = mask_q;

endmodule

/* hw/vmem_load_align.sv */
/*
 * Vector memory load result stage
 * Extracts and extends each returned element, presents the vector on done
 */
`timescale 1ns/1ps

module vmem_load_align (
  input  logic clk,
  input  logic resetn,
  input  logic lane_valid,
  input  logic [vmem_pkg::LANE_W-1:0] lane_idx,
  input  logic [1:0] lane_addr_lo,
  input  logic [vmem_pkg::WORD_W-1:0] lane_rdata,
  input  logic [1:0] op_size,
  input  logic op_signed,
  input  logic instr_end,
  input  logic end_we,
  input  logic [vmem_pkg::NUM_LANES-1:0] end_mask,
  output logic done,
  output logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] voutput,
  output logic [vmem_pkg::NUM_LANES-1:0] voutput_we
);
  import vmem_pkg::*;

  mem_word_t rword;
  logic [7:0] elem_b;
  logic [15:0] elem_h;
  logic [WORD_W-1:0] elem;
  logic [NUM_LANES-1:0][WORD_W-1:0] res_q;
  logic [NUM_LANES-1:0][WORD_W-1:0] vec_next;

  assign rword = lane_rdata;
  assign elem_b = rword.b[lane_addr_lo];
  assign elem_h = rword.h[lane_addr_lo[1]];

  always_comb
  begin
    case (op_size)
      SIZE_BYTE: elem = {{(WORD_W-8){op_signed & elem_b[7]}}, elem_b};
      SIZE_HALF: elem = {{(WORD_W-16){op_signed & elem_h[15]}}, elem_h};
      default: elem = rword;
    endcase
  end

  // Last beat arrives together with instr_end, bypass it in
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (lane_valid && lane_idx == LANE_W'(i))
        vec_next[i] = elem;
      else
        vec_next[i] = res_q[i];
    end
  end

  // Lane results, emptied at the end of each instruction
  always_ff @(posedge clk)
  begin
    if (!resetn || instr_end)
      res_q <= '0;
    else if (lane_valid)
      res_q[lane_idx] <= elem;
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      done <= 1'b0;
      voutput_we <= '0;
    end
    else
    begin
      done <= instr_end;
      voutput_we <= (instr_end && !end_we) ? end_mask : '0;
    end
  end

  // Masked lanes and stores read as zero
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_LANES; i++)
      voutput[i] <= (instr_end && !end_we && end_mask[i]) ? vec_next[i] : '0;
  end

endmodule

/* hw/vmem_unit.sv */
/*
 * Vector memory unit top level
 * Address generation, lane issue and load assembly as a three-stage pipe
 */
`timescale 1ns/1ps

module vmem_unit (
  input  logic clk,
  input  logic resetn,
  // Instruction port
  input  logic req_valid,
  output logic req_ready,
  input  logic [vmem_pkg::OP_W-1:0] op,
  input  logic [vmem_pkg::WORD_W-1:0] base,
  input  logic [vmem_pkg::WORD_W-1:0] stride,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] vindex,
  input  logic [vmem_pkg::NUM_LANES-1:0] vmask,
  input  logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] vwritedata,
  // Result port
  output logic done,
  output logic [vmem_pkg::NUM_LANES-1:0][vmem_pkg::WORD_W-1:0] voutput,
  output logic [vmem_pkg::NUM_LANES-1:0] voutput_we,
  // Wishbone classic master
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic [vmem_pkg::WORD_W-1:0] wb_adr,
  output logic [vmem_pkg::SEL_W-1:0] wb_sel,
  output logic [vmem_pkg::WORD_W-1:0] wb_dat_o,
  input  logic [vmem_pkg::WORD_W-1:0] wb_dat_i,
  input  logic wb_ack
);
  import vmem_pkg::*;

  // Stage 1 to stage 2
  logic gen_valid;
  logic gen_take;
  logic [OP_W-1:0] gen_op;
  logic [NUM_LANES-1:0][WORD_W-1:0] gen_addr;
  logic [NUM_LANES-1:0] gen_mask;
  logic [NUM_LANES-1:0][WORD_W-1:0] gen_wdata;

  // Stage 2 to stage 3
  logic lane_valid;
  logic [LANE_W-1:0] lane_idx;
  logic [1:0] lane_addr_lo;
  logic [WORD_W-1:0] lane_rdata;
  logic [1:0] lane_size;
  logic lane_signed;
  logic instr_end;
  logic end_we;
  logic [NUM_LANES-1:0] end_mask;

  vmem_addr_gen u_addr_gen (
    .clk        (clk),
    .resetn     (resetn),
    .req_valid  (req_valid),
    .op         (op),
    .base       (base),
    .stride     (stride),
    .vindex     (vindex),
    .vmask      (vmask),
    .vwritedata (vwritedata),
    .gen_take   (gen_take),
    .req_ready  (req_ready),
    .gen_valid  (gen_valid),
    .gen_op     (gen_op),
    .gen_addr   (gen_addr),
    .gen_mask   (gen_mask),
    .gen_wdata  (gen_wdata)
  );

  vmem_lane_issue u_lane_issue (
    .clk          (clk),
    .resetn       (resetn),
    .gen_valid    (gen_valid),
    .gen_op       (gen_op),
    .gen_addr     (gen_addr),
    .gen_mask     (gen_mask),
    .gen_wdata    (gen_wdata),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .gen_take     (gen_take),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_o     (wb_dat_o),
    .lane_valid   (lane_valid),
    .lane_idx     (lane_idx),
    .lane_addr_lo (lane_addr_lo),
    .lane_rdata   (lane_rdata),
    .lane_size    (lane_size),
    .lane_signed  (lane_signed),
    .instr_end    (instr_end),
    .end_we       (end_we),
    .end_mask     (end_mask)
  );

  vmem_load_align u_load_align (
    .clk          (clk),
    .resetn       (resetn),
    .lane_valid   (lane_valid),
    .lane_idx     (lane_idx),
    .lane_addr_lo (lane_addr_lo),
    .lane_rdata   (lane_rdata),
    .op_size      (lane_size),
    .op_signed    (lane_signed),
    .instr_end    (instr_end),
    .end_we       (end_we),
    .end_mask     (end_mask),
    .done         (done),
    .voutput      (voutput),
    .voutput_we   (voutput_we)
  );

endmodule

/* sim/wb_mem_model.sv */
/*
 * Wishbone classic slave memory for simulation
 * 256 words, 0 to 3 random wait states per access
 */
`timescale 1ns/1ps

module wb_mem_model (
  input  logic clk,
  input  logic resetn,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [31:0] adr,
  input  logic [3:0] sel,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic ack
);

  logic [31:0] mem [0:255];
  logic busy;
  logic [1:0] wait_left;
  logic [7:0] widx;
  integer seed = 32'ha8b8_3269;

  // Fill depends on every bit of the word address
  function automatic logic [31:0] fill_word(input logic [7:0] w);
    return ({4{w}} ^ 32'hc3a5_5a3c) ^ ({24'd0, w} << 13);
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(8'(i));
  end

  assign widx = adr[9:2];
  assign rdata = mem[widx];

  // First cycle of an access draws the wait count, ack is one cycle wide
  always @(posedge clk)
  begin
    if (!resetn)
    begin
      ack <= 1'b0;
      busy <= 1'b0;
      wait_left <= 2'd0;
    end
    else if (ack)
      ack <= 1'b0;
    else if (cyc && stb)
    begin
      if (!busy)
      begin
        busy <= 1'b1;
        wait_left <= 2'($random(seed));
      end
      else if (wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else
      begin
        ack <= 1'b1;
        busy <= 1'b0;
        // Byte lanes written as selected
        if (we)
          for (int k = 0; k < 4; k++)
            if (sel[k])
              mem[widx][8*k +: 8] = wdata[8*k +: 8];
      end
    end
  end

endmodule

/* sim/vmem_unit_tb.sv */
/*
 * Vector memory unit testbench
 * Reference byte memory, queued expected results, bus protocol checks
 */
`timescale 1ns/1ps

module vmem_unit_tb;
  import vmem_pkg::*;

  localparam int NUM_INSTR = 15;

  logic clk;
  logic resetn;
  logic req_valid;
  logic req_ready;
  logic [OP_W-1:0] op;
  logic [WORD_W-1:0] base;
  logic [WORD_W-1:0] stride;
  logic [NUM_LANES-1:0][WORD_W-1:0] vindex;
  logic [NUM_LANES-1:0] vmask;
  logic [NUM_LANES-1:0][WORD_W-1:0] vwritedata;
  logic done;
  logic [NUM_LANES-1:0][WORD_W-1:0] voutput;
  logic [NUM_LANES-1:0] voutput_we;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [WORD_W-1:0] wb_adr;
  logic [SEL_W-1:0] wb_sel;
  logic [WORD_W-1:0] wb_dat_o;
  logic [WORD_W-1:0] wb_dat_i;
  logic wb_ack;

  // Reference memory, one entry per byte address
  logic [7:0] ref_mem [0:1023];
  logic [NUM_LANES-1:0][WORD_W-1:0] exp_vec_q[$];
  logic [NUM_LANES-1:0] exp_we_q[$];
  int exp_acks_q[$];
  logic [NUM_LANES-1:0][WORD_W-1:0] exp_vec;
  logic [NUM_LANES-1:0] exp_we;
  int exp_acks;
  int errors = 0;
  int accepted = 0;
  int dones = 0;
  int ack_total = 0;
  int ack_mark = 0;

  vmem_unit UUT (
    .clk(clk), .resetn(resetn), .req_valid(req_valid), .req_ready(req_ready),
    .op(op), .base(base), .stride(stride), .vindex(vindex), .vmask(vmask),
    .vwritedata(vwritedata), .done(done), .voutput(voutput), .voutput_we(voutput_we),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_sel(wb_sel),
    .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
  );

  wb_mem_model u_mem (
    .clk(clk), .resetn(resetn), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
    .sel(wb_sel), .wdata(wb_dat_o), .rdata(wb_dat_i), .ack(wb_ack)
  );

  always #50 clk = ~clk;

  // Same fill as the memory model
  function automatic logic [31:0] fill_word(input logic [7:0] w);
    return ({4{w}} ^ 32'hc3a5_5a3c) ^ ({24'd0, w} << 13);
  endfunction

  // Byte address of one lane, element step is stride scaled by element size
  function automatic logic [31:0] lane_addr(input logic [1:0] pat, input logic [1:0] size,
      input logic [31:0] b, input logic [31:0] s, input logic [31:0] idx, input int i);
    case (pat)
      PAT_STRIDE: return b + ((s << size) * 32'(i));
      PAT_INDEX: return b + idx;
      default: return b + (32'(i) << size);
    endcase
  endfunction

  // Little-endian element read with optional sign extension
  function automatic logic [31:0] read_ref(input logic [31:0] a, input logic [1:0] size,
      input logic sgn);
    logic [9:0] p;
    p = a[9:0];
    case (size)
      SIZE_BYTE: return {{24{sgn & ref_mem[p][7]}}, ref_mem[p]};
      SIZE_HALF: return {{16{sgn & ref_mem[p + 10'd1][7]}}, ref_mem[p + 10'd1], ref_mem[p]};
      default: return {ref_mem[p + 10'd3], ref_mem[p + 10'd2], ref_mem[p + 10'd1], ref_mem[p]};
    endcase
  endfunction

  task automatic write_ref(input logic [31:0] a, input logic [1:0] size, input logic [31:0] d);
    logic [9:0] p;
    p = a[9:0];
    ref_mem[p] = d[7:0];
    if (size != SIZE_BYTE)
      ref_mem[p + 10'd1] = d[15:8];
    if (size == SIZE_WORD)
    begin
      ref_mem[p + 10'd2] = d[23:16];
      ref_mem[p + 10'd3] = d[31:24];
    end
  endtask

  // Queue the expected result, then hold the request until accepted
  task automatic send(input logic [1:0] pat, input logic [1:0] size, input logic sgn,
      input logic we, input logic [31:0] b, input logic [31:0] s,
      input logic [NUM_LANES-1:0][WORD_W-1:0] idx, input logic [NUM_LANES-1:0] m,
      input logic [NUM_LANES-1:0][WORD_W-1:0] wd);
    logic [NUM_LANES-1:0][WORD_W-1:0] ev;
    logic [31:0] a;
    int nacks;
    ev = '0;
    nacks = 0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (m[i])
      begin
        nacks++;
        a = lane_addr(pat, size, b, s, idx[i], i);
        if (we)
          write_ref(a, size, wd[i]);
        else
          ev[i] = read_ref(a, size, sgn);
      end
    end
    exp_vec_q.push_back(ev);
    exp_we_q.push_back(we ? 4'b0000 : m);
    exp_acks_q.push_back(nacks);
    @(posedge clk);
    #1;
    op = {pat, size, sgn, we};
    base = b;
    stride = s;
    vindex = idx;
    vmask = m;
    vwritedata = wd;
    req_valid = 1'b1;
    // req_ready only moves on rising edges
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    accepted++;
  endtask

  task automatic drain();
    while (exp_vec_q.size() != 0)
      @(negedge clk);
  endtask

  always @(posedge clk)
  begin
    if (resetn && wb_stb && wb_ack)
      ack_total <= ack_total + 1;
  end

  // Results come back in order, one done per instruction
  always @(negedge clk)
  begin
    if (resetn && done)
    begin
      dones++;
      if (exp_vec_q.size() == 0)
      begin
        errors++;
        $display("Unexpected done at %0t with no instruction outstanding", $time);
      end
      else
      begin
        exp_vec = exp_vec_q.pop_front();
        exp_we = exp_we_q.pop_front();
        exp_acks = exp_acks_q.pop_front();
        assert (voutput == exp_vec) else
        begin
          errors++;
          $display("Mismatch at %0t: voutput %h, expected %h", $time, voutput, exp_vec);
        end
        assert (voutput_we == exp_we) else
        begin
          errors++;
          $display("Mismatch at %0t: voutput_we %b, expected %b", $time, voutput_we, exp_we);
        end
        assert (ack_total - ack_mark == exp_acks) else
        begin
          errors++;
          $display("Mismatch at %0t: %0d acks, expected %0d", $time, ack_total - ack_mark,
            exp_acks);
        end
      end
      ack_mark = ack_total;
    end
  end

  // Idle outputs during reset and on the first cycle after it
  reset_idle: assert property (@(posedge clk) !resetn |=>
      !wb_cyc && !wb_stb && !done && voutput_we == '0 && req_ready) else
  begin
    errors++;
    $display("Mismatch at %0t: outputs not idle around reset", $time);
  end

  // Master holds the access steady through wait states
  bus_hold: assert property (@(posedge clk) disable iff (!resetn)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel) &&
      $stable(wb_we) && $stable(wb_dat_o)) else
  begin
    errors++;
    $display("Mismatch at %0t: bus outputs changed during a wait state", $time);
  end

  cyc_stb: assert property (@(posedge clk) disable iff (!resetn) wb_cyc == wb_stb) else
  begin
    errors++;
    $display("Mismatch at %0t: wb_cyc differs from wb_stb", $time);
  end

  done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done) else
  begin
    errors++;
    $display("Mismatch at %0t: done held longer than one cycle", $time);
  end

  initial
  begin
    repeat (NUM_INSTR * 40 + 16) @(posedge clk);
    $display("Timeout after %0d instructions accepted, %0d done", accepted, dones);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    logic [31:0] fw;
    clk = 1'b0;
    resetn = 1'b0;
    req_valid = 1'b0;
    op = '0;
    base = '0;
    stride = '0;
    vindex = '0;
    vmask = '0;
    vwritedata = '0;
    for (int w = 0; w < 256; w++)
    begin
      fw = fill_word(8'(w));
      for (int k = 0; k < 4; k++)
        ref_mem[4*w + k] = fw[8*k +: 8];
    end
    repeat (16) @(posedge clk);
    #1;
    resetn = 1'b1;

    // Unit-stride word store, then read it back
    send(PAT_UNIT, SIZE_WORD, 1'b0, 1'b1, 32'h40, 32'd0, '0, 4'b1111,
      {32'hdead_beef, 32'h0123_4567, 32'h89ab_cdef, 32'h7f00_80ff});
    drain();
    send(PAT_UNIT, SIZE_WORD, 1'b0, 1'b0, 32'h40, 32'd0, '0, 4'b1111, '0);
    drain();
    // Strided byte and halfword loads, both extensions
    send(PAT_STRIDE, SIZE_BYTE, 1'b1, 1'b0, 32'h101, 32'd5, '0, 4'b1111, '0);
    drain();
    send(PAT_STRIDE, SIZE_BYTE, 1'b0, 1'b0, 32'h101, 32'd5, '0, 4'b1111, '0);
    drain();
    send(PAT_STRIDE, SIZE_HALF, 1'b1, 1'b0, 32'h102, 32'd3, '0, 4'b1101, '0);
    drain();
    send(PAT_STRIDE, SIZE_HALF, 1'b0, 1'b0, 32'h102, 32'd3, '0, 4'b1111, '0);
    drain();
    // Indexed byte store on lanes 1 and 3, readback by byte and by word
    send(PAT_INDEX, SIZE_BYTE, 1'b0, 1'b1, 32'h200, 32'd0,
      {32'h32, 32'h21, 32'h10, 32'h03}, 4'b1010,
      {32'h0000_00a5, 32'h0000_0011, 32'h0000_005c, 32'h0000_0022});
    drain();
    send(PAT_INDEX, SIZE_BYTE, 1'b0, 1'b0, 32'h200, 32'd0,
      {32'h32, 32'h21, 32'h10, 32'h03}, 4'b1111, '0);
    drain();
    send(PAT_STRIDE, SIZE_WORD, 1'b0, 1'b0, 32'h200, 32'd4, '0, 4'b1111, '0);
    drain();
    // All lanes masked, no bus cycle
    send(PAT_UNIT, SIZE_WORD, 1'b0, 1'b0, 32'h80, 32'd0, '0, 4'b0000, '0);
    drain();
    send(PAT_UNIT, SIZE_WORD, 1'b0, 1'b1, 32'h80, 32'd0, '0, 4'b0000, '0);
    drain();
    // Back to back, stage 1 fills and req_ready drops
    send(PAT_STRIDE, SIZE_HALF, 1'b0, 1'b1, 32'h300, 32'd2, '0, 4'b1111,
      {32'h0000_8001, 32'h0000_7ffe, 32'h0000_c3c3, 32'h0000_0f0f});
    send(PAT_UNIT, SIZE_BYTE, 1'b0, 1'b1, 32'h311, 32'd0, '0, 4'b0111,
      {32'h0000_0099, 32'h0000_0080, 32'h0000_007f, 32'h0000_00e1});
    send(PAT_UNIT, SIZE_WORD, 1'b0, 1'b0, 32'h300, 32'd0, '0, 4'b1111, '0);
    send(PAT_UNIT, SIZE_BYTE, 1'b1, 1'b0, 32'h310, 32'd0, '0, 4'b1111, '0);
    drain();
    repeat (4) @(posedge clk);

    assert (accepted == dones) else
    begin
      errors++;
      $display("Mismatch at %0t: %0d done pulses, expected %0d", $time, dones, accepted);
    end
    $display("Errors: %0d, instructions: %0d, done pulses: %0d, acks: %0d",
      errors, accepted, dones, ack_total);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* list.f */
hw/vmem_pkg.sv
hw/vmem_store_align.sv
hw/vmem_addr_gen.sv
hw/vmem_lane_issue.sv
hw/vmem_load_align.sv
hw/vmem_unit.sv
sim/wb_mem_model.sv
sim/vmem_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the vector memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module vmem_unit_tb -f list.f -o vmem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/vmem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
